//--- bench/fetch_checker.sv
`timescale 1ns/10ps

module fetch_checker import fetch_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       wb_cyc,
    input logic       wb_stb,
    input pc_t        wb_adr,
    input logic       wb_ack,
    input logic       out_ready,
    input fetch_out_t fetch_out
);

    // One sticky bit per property
    bit   stb_err  = 1'b0;
    bit   adr_err  = 1'b0;
    bit   hold_err = 1'b0;
    bit   req_err  = 1'b0;
    // Seen from the testbench
    logic failed;

    assign failed = stb_err || adr_err || hold_err || req_err;

    //////////////////////////////////////////////////////////////////////
    // Wishbone master side
    //////////////////////////////////////////////////////////////////////

    // Strobe only inside a bus cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            stb_err = 1'b1;
        end

    // Address held until the slave acks
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr))
        else begin
            $error("wb_adr changed before wb_ack");
            adr_err = 1'b1;
        end

    //////////////////////////////////////////////////////////////////////
    // Output register under back-pressure
    //////////////////////////////////////////////////////////////////////

    // Stalled bundle must not move
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_out.valid && !out_ready |=> $stable(fetch_out))
        else begin
            $error("fetch_out changed while stalled");
            hold_err = 1'b1;
        end

    // No new bus cycle while the output is stuck
    a_no_req_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_out.valid && !out_ready && !wb_cyc |=> !wb_cyc)
        else begin
            $error("bus request started while output held");
            req_err = 1'b1;
        end

endmodule

bind fetch_ctrl fetch_checker i_fetch_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_ack    (wb_ack),
    .out_ready (out_ready),
    .fetch_out (fetch_out)
);

//--- bench/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 16;
    localparam int          NROWS        = 20;
    // Cycle budget of 20 per row plus reset
    localparam int          WATCHDOG_CYC = NROWS * 20 + RESET_CYCLES;
    localparam logic [31:0] SEED         = 32'h1c66_78ae;

    // Groups written with slot 3 on the left
    localparam fetch_group_t G_PLAIN0 = 64'h1003_1002_1001_1000;
    localparam fetch_group_t G_PLAIN4 = 64'h2007_2006_2005_2004;
    // Branch in slot 2 with offset +0x10
    localparam fetch_group_t G_BR08   = 64'h300B_C010_3009_3008;
    // Branch in slot 1 with offset -0x0C
    localparam fetch_group_t G_BR1A   = 64'h401D_401C_CFF4_401A;
    // Branches in slots 1 and 3
    localparam fetch_group_t G_TWO0F  = 64'hC7FF_5011_C020_500F;
    localparam fetch_group_t G_BR30   = 64'h6033_6032_6031_C008;
    // Branches in slots 0 and 2
    localparam fetch_group_t G_TWO38  = 64'h703B_C100_7039_C005;
    localparam fetch_group_t G_BR3C   = 64'hC001_803E_803D_803C;
    // Loop in slot 1 back to 0x30 and branch in slot 3
    localparam fetch_group_t G_LOOP40 = 64'hC004_9042_DFEF_9040;
    // Branch in slot 2 to address 0 and branch in slot 3
    localparam fetch_group_t G_TWO34  = 64'hC002_CFCA_A035_A034;

    // Back-end reports {branch_done, mispredict, mispred_second, pred_taken}
    localparam commit_t CM_NONE     = 4'b0000;
    localparam commit_t CM_DONE_NT  = 4'b1000;
    localparam commit_t CM_DONE_T   = 4'b1001;
    localparam commit_t CM_MISP_NT  = 4'b0100;
    localparam commit_t CM_MISP_T   = 4'b0101;
    localparam commit_t CM_MISP2_NT = 4'b0110;
    localparam commit_t CM_MISP2_T  = 4'b0111;

    // One expected output transfer
    typedef struct packed {
        pc_t          addr;
        fetch_group_t group;
        commit_t      commit;
        pcsel_t       pcsel;
        pc_t          next_addr;
    } row_t;

    logic         clk;
    logic         rst_n;
    fetch_group_t wb_dat_i;
    logic         wb_ack;
    commit_t      commit;
    logic         out_ready;
    logic         wb_cyc;
    logic         wb_stb;
    pc_t          wb_adr;
    fetch_out_t   fetch_out;

    row_t rows [NROWS];
    // Bus requests seen so far
    int   req_cnt;
    int   wait_left;
    logic req_open;
    // Rows that have left the output register
    int   drv_row;

    fetch_top i_fetch_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .commit    (commit),
        .out_ready (out_ready),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .fetch_out (fetch_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Table and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic set_row(input int idx, input pc_t addr, input fetch_group_t group,
                           input commit_t cm, input pcsel_t sel, input pc_t next_addr);
        rows[idx] = '{addr, group, cm, sel, next_addr};
    endtask

    // Counter state before each row in the trailing comment
    task automatic load_table();
        set_row(0,  16'h0000, G_PLAIN0, CM_NONE,     PCSEL_SEQ,       16'h0004); // ST
        set_row(1,  16'h0004, G_PLAIN4, CM_NONE,     PCSEL_SEQ,       16'h0008); // ST
        set_row(2,  16'h0008, G_BR08,   CM_NONE,     PCSEL_TGT_ONLY,  16'h001A); // ST
        set_row(3,  16'h001A, G_BR1A,   CM_NONE,     PCSEL_TGT_ONLY,  16'h000F); // ST
        set_row(4,  16'h000F, G_TWO0F,  CM_DONE_NT,  PCSEL_TGT_FIRST, 16'h0030); // ST
        set_row(5,  16'h0030, G_BR30,   CM_DONE_NT,  PCSEL_TGT_ONLY,  16'h0038); // WT
        set_row(6,  16'h0038, G_TWO38,  CM_MISP_NT,  PCSEL_SEQ,       16'h003C); // WN
        set_row(7,  16'h003C, G_BR3C,   CM_MISP_T,   PCSEL_TGT_ONLY,  16'h0040); // WT
        set_row(8,  16'h0040, G_LOOP40, CM_MISP2_NT, PCSEL_TGT_FIRST, 16'h0030); // SN
        set_row(9,  16'h0030, G_BR30,   CM_MISP2_T,  PCSEL_TGT_ONLY,  16'h0038); // WT
        set_row(10, 16'h0038, G_TWO38,  CM_DONE_T,   PCSEL_SEQ,       16'h003C); // SN
        set_row(11, 16'h003C, G_BR3C,   CM_MISP2_NT, PCSEL_SEQ,       16'h0040); // WN
        set_row(12, 16'h0040, G_LOOP40, CM_MISP2_T,  PCSEL_TGT_FIRST, 16'h0030); // ST
        set_row(13, 16'h0030, G_BR30,   CM_DONE_T,   PCSEL_SEQ,       16'h0034); // WN
        set_row(14, 16'h0034, G_TWO34,  CM_MISP_T,   PCSEL_TGT_FIRST, 16'h0000); // WT
        set_row(15, 16'h0000, G_PLAIN0, CM_MISP_T,   PCSEL_SEQ,       16'h0004); // SN
        set_row(16, 16'h0004, G_PLAIN4, CM_MISP_NT,  PCSEL_SEQ,       16'h0008); // SN
        set_row(17, 16'h0008, G_BR08,   CM_DONE_T,   PCSEL_SEQ,       16'h000C); // WN
        // Unlisted addresses read as zero
        set_row(18, 16'h000C, '0,       CM_DONE_T,   PCSEL_SEQ,       16'h0010); // WT
        set_row(19, 16'h0010, '0,       CM_NONE,     PCSEL_SEQ,       16'h0014); // ST
    endtask

    function automatic fetch_group_t mem_read(input pc_t adr);
        fetch_group_t data;
        data = '0;
        // Walk down so the first matching row wins
        for (int i = NROWS - 1; i >= 0; i--) begin
            if (rows[i].addr == adr) begin
                data = rows[i].group;
            end
        end
        return data;
    endfunction

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_group(input string name, input fetch_group_t got,
                               input fetch_group_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_pcsel(input string name, input pcsel_t got, input pcsel_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %b, expected %b", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Returns at the edge that closes a transfer cycle
    task automatic wait_transfer();
        @(posedge clk);
        while (!(fetch_out.valid && out_ready)) begin
            @(posedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Wishbone memory and output side drivers
    //////////////////////////////////////////////////////////////////////

    // Slave with 0 to 3 random wait cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            wb_dat_i  <= '0;
            wait_left = $urandom_range(3, 0);
            req_open  = 1'b0;
            req_cnt   = 0;
        end else if (wb_ack) begin
            // Single-cycle ack
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!req_open) begin
                req_open = 1'b1;
                // Each request goes where the row before it pointed
                if (req_cnt == 0) begin
                    check_pc("wb_adr", wb_adr, rows[0].addr);
                end else if (req_cnt <= NROWS) begin
                    check_pc("wb_adr", wb_adr, rows[req_cnt - 1].next_addr);
                end
                req_cnt++;
            end
            if (wait_left == 0) begin
                wb_ack    <= 1'b1;
                wb_dat_i  <= mem_read(wb_adr);
                wait_left = $urandom_range(3, 0);
                req_open  = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // Ready 3 times in 4 and commit only in the transfer cycle
    always @(posedge clk) begin : drive_out
        logic valid_next;
        logic ready_next;
        if (!rst_n) begin
            out_ready <= 1'b0;
            commit    <= '0;
            drv_row   = 0;
        end else begin
            if (fetch_out.valid && out_ready) begin
                drv_row++;
            end
            // Output register contents for the coming cycle
            valid_next = wb_ack || (fetch_out.valid && !out_ready);
            ready_next = ($urandom_range(3, 0) != 0);
            out_ready <= ready_next;
            if (valid_next && ready_next && drv_row < NROWS) begin
                commit <= rows[drv_row].commit;
            end else begin
                commit <= '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sequence, protocol monitor, watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        void'($urandom(SEED));
        clk       = 1'b0;
        rst_n     = 1'b0;
        wb_dat_i  = '0;
        wb_ack    = 1'b0;
        commit    = '0;
        out_ready = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NROWS; i++) begin
            wait_transfer();
            check_pc("fetch_out.pc", fetch_out.pc, rows[i].addr);
            check_group("fetch_out.group", fetch_out.group, rows[i].group);
            check_pcsel("fetch_out.pcsel", fetch_out.pcsel, rows[i].pcsel);
        end
        // Request after the last row carries its next address
        while (req_cnt <= NROWS) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (!i_fetch_top.i_fetch_ctrl.i_fetch_checker.failed) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("A bus or output protocol assertion failed");
            $display("*** TEST FAILED ***");
            $fatal(1, "Protocol error");
        end
    end

    always @(posedge clk) begin
        if (i_fetch_top.i_fetch_ctrl.i_fetch_checker.failed) begin
            $display("A bus or output protocol assertion failed");
            $display("*** TEST FAILED ***");
            $fatal(1, "Protocol error");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Watchdog expired, an expected output transfer never arrived");
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    end

endmodule

//--- flist.f
hw/fetch_pkg.sv
hw/branch_scan.sv
hw/dyn_branch_predictor.sv
hw/fetch_ctrl.sv
hw/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

//--- hw/branch_scan.sv
`timescale 1ns/10ps

module branch_scan import fetch_pkg::*; (
    input  fetch_group_t group,
    input  pc_t          pc,
    output scan_t        scan
);

    // Branch or loop per slot
    logic [FETCH_WIDTH-1:0] br_mask;
    // Index of the lowest branch slot
    logic [SLOT_W-1:0]      first_slot;
    instr_t                 first_instr;
    // Address of that slot
    pc_t                    slot_pc;
    // Offset widened to a full address
    pc_t                    offset_ext;

    //////////////////////////////////////////////////////////////////////
    // Opcode compare per slot
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            // Both kinds redirect fetch
            br_mask[i] = (group[i].opcode == OP_BRANCH) ||
                         (group[i].opcode == OP_LOOP);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Priority encoder for the lowest slot
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Slot 0 when the group has no branch
        first_slot = '0;
        // Walk down so the lowest hit is written last
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (br_mask[i]) begin
                first_slot = SLOT_W'(i);
            end
        end
    end

    assign first_instr = group[first_slot];

    // Target is relative to the branch's own word
    assign slot_pc    = pc + pc_t'(first_slot);
    assign offset_ext = {{(PC_W - OFFSET_W){first_instr.offset[OFFSET_W-1]}},
                         first_instr.offset};

    // Pack the result
    assign scan.br_mask    = br_mask;
    // Slot 0 of an empty mask is never a loop
    assign scan.loop_first = (first_instr.opcode == OP_LOOP);
    assign scan.target     = slot_pc + offset_ext;

endmodule

//--- hw/dyn_branch_predictor.sv
`timescale 1ns/10ps

module dyn_branch_predictor import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  commit_t commit,
    input  logic    fetch_ack,
    input  scan_t   scan,
    output pcsel_t  pcsel
);

    // Single shared counter, no per-address state
    pred_state_t ctr;
    pred_state_t ctr_nxt;
    // Branches in the group, 0 to FETCH_WIDTH
    logic [SLOT_W:0] n_br;

    // One step toward ST, saturating
    function automatic pred_state_t sat_up(input pred_state_t s);
        case (s)
            SN:      return WN;
            WN:      return WT;
            default: return ST;
        endcase
    endfunction

    // One step toward SN, saturating
    function automatic pred_state_t sat_down(input pred_state_t s);
        case (s)
            ST:      return WT;
            WT:      return WN;
            default: return SN;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Counter training
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctr_nxt = ctr;
        // Commit beats mispredict
        if (commit.branch_done) begin
            ctr_nxt = commit.pred_taken ? sat_up(ctr) : sat_down(ctr);
        end else if (commit.mispredict) begin
            if (commit.mispred_second) begin
                // Second branch of its group, hard retrain
                if (commit.pred_taken) begin
                    ctr_nxt = (ctr == ST) ? WN : SN;
                end else begin
                    ctr_nxt = (ctr == SN) ? WT : ST;
                end
            end else if (commit.pred_taken) begin
                // Wrongly taken, two steps down
                ctr_nxt = sat_down(sat_down(ctr));
            end else begin
                // Wrongly not taken
                ctr_nxt = sat_up(ctr);
            end
        end
    end

    // Starts strongly taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctr <= ST;
        end else begin
            ctr <= ctr_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next-PC select
    //////////////////////////////////////////////////////////////////////

    // Population count of the mask
    always_comb begin
        n_br = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (scan.br_mask[i]) begin
                n_br = n_br + 1'b1;
            end
        end
    end

    always_comb begin
        pcsel = PCSEL_SEQ;
        if (fetch_ack) begin
            if (scan.loop_first) begin
                // Loops ignore the counter
                pcsel = PCSEL_TGT_FIRST;
            end else if (n_br == 1) begin
                pcsel = ctr[1] ? PCSEL_TGT_ONLY : PCSEL_SEQ;
            end else if (n_br > 1) begin
                pcsel = ctr[1] ? PCSEL_TGT_FIRST : PCSEL_SEQ;
            end
        end
    end

endmodule

//--- hw/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  fetch_group_t wb_dat_i,
    input  logic         wb_ack,
    input  logic         out_ready,
    input  pcsel_t       pcsel,
    input  pc_t          target,
    output logic         wb_cyc,
    output logic         wb_stb,
    output pc_t          wb_adr,
    output logic         fetch_ack,
    output pc_t          pc,
    output fetch_out_t   fetch_out
);

    fetch_state_t state;
    fetch_state_t state_nxt;

    // Output register, valid has reset, payload does not
    logic         out_valid;
    pc_t          out_pc;
    fetch_group_t out_group;
    pcsel_t       out_pcsel;

    // Handshake at the output
    logic out_xfer;
    // Register empty now or emptied this cycle
    logic out_free;

    assign out_xfer = out_valid && out_ready;
    assign out_free = !out_valid || out_ready;

    //////////////////////////////////////////////////////////////////////
    // Wishbone classic read
    //////////////////////////////////////////////////////////////////////

    // Ack only counts inside our own cycle
    assign fetch_ack = (state == FS_BUSY) && wb_ack;

    always_comb begin
        state_nxt = state;
        case (state)
            FS_IDLE: begin
                // New request only if the ack data will have a home
                if (out_free) begin
                    state_nxt = FS_BUSY;
                end
            end
            FS_BUSY: begin
                // Cycle ends on ack, cyc drops next cycle
                if (wb_ack) begin
                    state_nxt = FS_IDLE;
                end
            end
            default: state_nxt = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // cyc and stb move together
    assign wb_cyc = (state == FS_BUSY);
    assign wb_stb = (state == FS_BUSY);
    // pc only changes at ack, so adr holds for the whole cycle
    assign wb_adr = pc;

    //////////////////////////////////////////////////////////////////////
    // PC and output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (fetch_ack) begin
            // Fall through or redirect
            pc <= (pcsel == PCSEL_SEQ) ? pc + pc_t'(FETCH_WIDTH) : target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (fetch_ack) begin
            out_valid <= 1'b1;
        end else if (out_xfer) begin
            out_valid <= 1'b0;
        end
    end

    // Captured with the pc of the request, before it advances
    always_ff @(posedge clk) begin
        if (fetch_ack) begin
            out_pc    <= pc;
            out_group <= wb_dat_i;
            out_pcsel <= pcsel;
        end
    end

    assign fetch_out.valid = out_valid;
    assign fetch_out.pc    = out_pc;
    assign fetch_out.group = out_group;
    assign fetch_out.pcsel = out_pcsel;

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Word addresses, one instruction per word
    localparam int PC_W        = 16;
    localparam int OPCODE_W    = 4;
    localparam int OFFSET_W    = 12;
    // Slots per fetch group
    localparam int FETCH_WIDTH = 4;
    localparam int SLOT_W      = $clog2(FETCH_WIDTH);

    // Control-flow opcodes
    // Conditional branch
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 4'hC;
    // Loop back-edge, always taken
    localparam logic [OPCODE_W-1:0] OP_LOOP   = 4'hD;

    typedef logic [PC_W-1:0] pc_t;

    // Opcode on top, signed word offset below
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        logic [OFFSET_W-1:0] offset;
    } instr_t;

    // Slot 0 in the low bits, holds the word at pc
    typedef instr_t [FETCH_WIDTH-1:0] fetch_group_t;

    //////////////////////////////////////////////////////////////////////
    // Predictor and next-PC encodings
    //////////////////////////////////////////////////////////////////////

    // Bit 1 is the taken prediction
    typedef enum logic [1:0] {
        SN = 2'b00,
        WN = 2'b01,
        WT = 2'b10,
        ST = 2'b11
    } pred_state_t;

    // Next-PC select, 01 unused
    typedef enum logic [1:0] {
        PCSEL_SEQ       = 2'b00,
        PCSEL_TGT_ONLY  = 2'b10,
        PCSEL_TGT_FIRST = 2'b11
    } pcsel_t;

    // Bus read FSM
    typedef enum logic {
        FS_IDLE = 1'b0,
        FS_BUSY = 1'b1
    } fetch_state_t;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////

    // Scan result for one group
    typedef struct packed {
        logic [FETCH_WIDTH-1:0] br_mask;
        logic                   loop_first;
        pc_t                    target;
    } scan_t;

    // Back-end report, one per cycle
    typedef struct packed {
        logic branch_done;
        logic mispredict;
        logic mispred_second;
        logic pred_taken;
    } commit_t;

    // Group handed to decode
    typedef struct packed {
        logic         valid;
        pc_t          pc;
        fetch_group_t group;
        pcsel_t       pcsel;
    } fetch_out_t;

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  fetch_group_t wb_dat_i,
    input  logic         wb_ack,
    input  commit_t      commit,
    input  logic         out_ready,
    output logic         wb_cyc,
    output logic         wb_stb,
    output pc_t          wb_adr,
    output fetch_out_t   fetch_out
);

    // Current fetch address
    pc_t    pc;
    // Scan of the data on the bus
    scan_t  scan;
    pcsel_t pcsel;
    // Bus ack inside our cycle
    logic   fetch_ack;

    //////////////////////////////////////////////////////////////////////
    // Scan, predict, fetch
    //////////////////////////////////////////////////////////////////////

    // Looks at read data in the ack cycle
    branch_scan i_branch_scan (
        .group (wb_dat_i),
        .pc    (pc),
        .scan  (scan)
    );

    dyn_branch_predictor i_dyn_branch_predictor (
        .clk       (clk),
        .rst_n     (rst_n),
        .commit    (commit),
        .fetch_ack (fetch_ack),
        .scan      (scan),
        .pcsel     (pcsel)
    );

    fetch_ctrl i_fetch_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .out_ready (out_ready),
        .pcsel     (pcsel),
        .target    (scan.target),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .fetch_ack (fetch_ack),
        .pc        (pc),
        .fetch_out (fetch_out)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fetch_tb \
    -f flist.f \
    -o fetch_sim

# Exit status of the run is ignored, the log decides
./obj_dir/fetch_sim +verilator+error+limit+100 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation done, see $LOG"
